// File: build.f
spi_cmd_pkg.sv
sync_sig.sv
spi_iff.sv
cmd_exec.sv
reg_bank.sv
spi_cmd_top.sv
spi_checker.sv
tb_spi_cmd.sv

// File: cmd_exec.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_exec (
    input  wire                              clk,
    input  wire                              nrst,
    input  wire  [spi_cmd_pkg::CMD_W-1:0]    cmd_read,
    input  wire                              cmd_valid,
    output logic [spi_cmd_pkg::RESP_W-1:0]   resp_word,
    output logic                             wr_en,
    output logic [spi_cmd_pkg::REG_AW-1:0]   addr,
    output logic [spi_cmd_pkg::DATA_W-1:0]   wdata,
    input  wire  [spi_cmd_pkg::DATA_W-1:0]   rdata
);

    logic [spi_cmd_pkg::OP_MSB-spi_cmd_pkg::OP_LSB:0] opcode;
    logic                                             addr_ok;
    logic [7:0]                                       status;
    logic [spi_cmd_pkg::DATA_W-1:0]                   rsp_data;
    logic                                             wr_req;

    // ~~~~~~~~~~~~~~~~~~~~
    // field split
    // ~~~~~~~~~~~~~~~~~~~~
    assign opcode = cmd_read[spi_cmd_pkg::OP_MSB:spi_cmd_pkg::OP_LSB];
    assign addr   = cmd_read[spi_cmd_pkg::ADDR_LSB +: spi_cmd_pkg::REG_AW];
    assign wdata  = cmd_read[spi_cmd_pkg::DATA_MSB:spi_cmd_pkg::DATA_LSB];

    // upper address bits must be clear for the sixteen registers
    assign addr_ok = ~|cmd_read[spi_cmd_pkg::ADDR_MSB:spi_cmd_pkg::ADDR_LSB + spi_cmd_pkg::REG_AW];

    // ~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        status   = spi_cmd_pkg::ST_OK;
        rsp_data = '0;
        wr_req   = 1'b0;
        case (opcode)
            spi_cmd_pkg::OP_NOP: begin
                status = spi_cmd_pkg::ST_OK;       // nothing to do.
            end
            spi_cmd_pkg::OP_WRITE: begin
                if (addr_ok) begin
                    wr_req   = 1'b1;
                    rsp_data = wdata;              // echo what was written.
                end else begin
                    status = spi_cmd_pkg::ST_BAD_ADDR;
                end
            end
            spi_cmd_pkg::OP_READ: begin
                if (addr_ok) begin
                    rsp_data = rdata;
                end else begin
                    status = spi_cmd_pkg::ST_BAD_ADDR;
                end
            end
            default: begin
                status = spi_cmd_pkg::ST_BAD_OP;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // write strobe and response
    // ~~~~~~~~~~~~~~~~~~~~
    // addr and wdata stay valid because cmd_read holds until the next frame
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_en     <= 1'b0;
            resp_word <= '0;
        end else begin
            wr_en <= cmd_valid & wr_req;
            if (cmd_valid) begin
                resp_word <= {opcode, status, rsp_data};
            end
        end
    end

endmodule

`default_nettype wire

// File: reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
    input  wire                              clk,
    input  wire                              nrst,
    input  wire                              wr_en,
    input  wire  [spi_cmd_pkg::REG_AW-1:0]   addr,
    input  wire  [spi_cmd_pkg::DATA_W-1:0]   wdata,
    output logic [spi_cmd_pkg::DATA_W-1:0]   rdata
);

    logic [spi_cmd_pkg::DATA_W-1:0] regs [spi_cmd_pkg::REG_NUM];

    // ~~~~~~~~~~~~~~~~~~~~
    // write port
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < spi_cmd_pkg::REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[addr] <= wdata;            // single write per strobe.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~
    assign rdata = regs[addr];              // no read latency.

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_spi_cmd -f build.f -o sim_spi_cmd
./obj_dir/sim_spi_cmd | tee sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: spi_checker.sv
`timescale 1ns/1ps
`default_nettype none

module spi_checker (
    input  wire  clk,
    input  wire  spi_clk,
    input  wire  spi_ss,
    input  wire  spi_miso,
    output int   pass_cnt,
    output int   fail_cnt,
    output logic done,
    output logic hung
);

    localparam int MAX_FRAMES = 64;
    localparam int WAIT_LIMIT = 2000;              // clk cycles per edge wait.

    int                               exp_len [MAX_FRAMES];
    logic [spi_cmd_pkg::RESP_W-1:0]   exp_rsp [MAX_FRAMES];
    int                               num_frames;
    logic [spi_cmd_pkg::RESP_W-1:0]   got;
    int                               got_bits;
    logic                             tail_high;   // miso seen high past the response.

    task automatic load_expected(output int count);
        int                             fd;
        int                             len;
        logic [spi_cmd_pkg::CMD_W-1:0]  cmd;
        logic [spi_cmd_pkg::RESP_W-1:0] rsp;
        string                          line;
        count = 0;
        fd = $fopen("spi_stim.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%d %h %h", len, cmd, rsp) == 3 && count < MAX_FRAMES) begin
                exp_len[count] = len;
                exp_rsp[count] = rsp;
                count++;
            end
        end
        $fclose(fd);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // pin watching
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic wait_level(input logic level, output bit ok);
        int cnt;
        cnt = 0;
        while (spi_ss !== level && cnt < WAIT_LIMIT) begin
            @(negedge clk);                        // pins settle after the rising edge.
            cnt++;
        end
        ok = (spi_ss === level);
    endtask

    task automatic capture_frame(output bit ok);
        int   cnt;
        logic prev;
        cnt       = 0;
        prev      = spi_clk;
        got       = '0;
        got_bits  = 0;
        tail_high = 1'b0;
        ok        = 1'b1;
        while (spi_ss == 1'b0 && ok) begin
            @(negedge clk);
            if (spi_clk && !prev) begin
                if (got_bits < spi_cmd_pkg::RESP_W) begin
                    got[spi_cmd_pkg::RESP_W-1-got_bits] = spi_miso;
                end else if (spi_miso !== 1'b0) begin
                    tail_high = 1'b1;              // miso idles low after the response.
                end
                got_bits++;
                cnt = 0;
            end else begin
                cnt++;
                ok = (cnt < WAIT_LIMIT);           // no spi_clk edge for too long.
            end
            prev = spi_clk;
        end
    endtask

    // short frames only carry the top bits of the response
    task automatic check_frame(input int f);
        int                             nbits;
        logic [spi_cmd_pkg::RESP_W-1:0] keep;
        nbits = (exp_len[f] < spi_cmd_pkg::RESP_W) ? exp_len[f] : spi_cmd_pkg::RESP_W;
        keep  = ~({spi_cmd_pkg::RESP_W{1'b1}} >> nbits);
        if (got_bits != exp_len[f]) begin
            $display("FAILED at %0t: frame %0d had %0d bits, expected %0d",
                     $time, f, got_bits, exp_len[f]);
            fail_cnt++;
        end else if ((got & keep) !== (exp_rsp[f] & keep)) begin
            $display("FAILED at %0t: frame %0d response %h, expected %h",
                     $time, f, got & keep, exp_rsp[f] & keep);
            fail_cnt++;
        end else if (tail_high) begin
            $display("FAILED at %0t: frame %0d miso not low after bit %0d",
                     $time, f, spi_cmd_pkg::RESP_W);
            fail_cnt++;
        end else begin
            $display("frame %0d ok, %0d bits, response %h", f, got_bits, got & keep);
            pass_cnt++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // frame loop
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        bit ok;
        pass_cnt  = 0;
        fail_cnt  = 0;
        done      = 1'b0;
        hung      = 1'b0;
        tail_high = 1'b0;
        load_expected(num_frames);
        if (num_frames <= 0) begin
            $display("checker could not read any frame from spi_stim.txt");
            fail_cnt = 1;
        end
        for (int f = 0; f < num_frames && !hung; f++) begin
            wait_level(1'b0, ok);
            if (!ok) begin
                $display("timed out waiting for frame %0d to start", f);
                hung = 1'b1;
            end else begin
                capture_frame(ok);
                if (!ok) begin
                    $display("timed out waiting for a clock edge in frame %0d", f);
                    hung = 1'b1;
                end else begin
                    check_frame(f);
                end
            end
        end
        done = 1'b1;
    end

endmodule

`default_nettype wire

// File: spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // frame geometry
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int CMD_W  = 56;      // bits per command frame.
    localparam int RESP_W = 48;      // bits per response word.

    // command word fields, msb first on the wire
    localparam int OP_MSB   = 55;
    localparam int OP_LSB   = 48;
    localparam int ADDR_MSB = 47;
    localparam int ADDR_LSB = 32;
    localparam int DATA_MSB = 31;
    localparam int DATA_LSB = 0;

    // ~~~~~~~~~~~~~~~~~~~~
    // register bank
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int REG_NUM = 16;     // number of registers.
    localparam int REG_AW  = 4;      // index width.
    localparam int DATA_W  = 32;     // register width.

    // ~~~~~~~~~~~~~~~~~~~~
    // opcodes and status
    // ~~~~~~~~~~~~~~~~~~~~
    localparam logic [7:0] OP_NOP   = 8'h00;
    localparam logic [7:0] OP_WRITE = 8'h01;
    localparam logic [7:0] OP_READ  = 8'h02;

    localparam logic [7:0] ST_OK       = 8'h00;
    localparam logic [7:0] ST_BAD_OP   = 8'h01;   // opcode not recognised.
    localparam logic [7:0] ST_BAD_ADDR = 8'h02;   // address outside the bank.

endpackage

`default_nettype wire

// File: spi_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_top (
    input  wire  clk,
    input  wire  nrst,
    input  wire  spi_clk,
    input  wire  spi_ss,
    input  wire  spi_mosi,
    output logic spi_miso
);

    logic [spi_cmd_pkg::CMD_W-1:0]  cmd_read;
    logic                           cmd_valid;
    logic [spi_cmd_pkg::RESP_W-1:0] resp_word;
    logic                           wr_en;
    logic [spi_cmd_pkg::REG_AW-1:0] addr;
    logic [spi_cmd_pkg::DATA_W-1:0] wdata;
    logic [spi_cmd_pkg::DATA_W-1:0] rdata;

    // ~~~~~~~~~~~~~~~~~~~~
    // spi front end
    // ~~~~~~~~~~~~~~~~~~~~
    spi_iff u_spi_iff (
        .clk       (clk),
        .nrst      (nrst),
        .spi_clk   (spi_clk),
        .spi_ss    (spi_ss),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .cmd_read  (cmd_read),
        .cmd_valid (cmd_valid),
        .resp_word (resp_word)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // command path
    // ~~~~~~~~~~~~~~~~~~~~
    cmd_exec u_cmd_exec (
        .clk       (clk),
        .nrst      (nrst),
        .cmd_read  (cmd_read),
        .cmd_valid (cmd_valid),
        .resp_word (resp_word),
        .wr_en     (wr_en),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata)
    );

    reg_bank u_reg_bank (
        .clk   (clk),
        .nrst  (nrst),
        .wr_en (wr_en),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata)
    );

endmodule

`default_nettype wire

// File: spi_iff.sv
`timescale 1ns/1ps
`default_nettype none

module spi_iff (
    input  wire                              clk,
    input  wire                              nrst,
    input  wire                              spi_clk,
    input  wire                              spi_ss,
    input  wire                              spi_mosi,
    output logic                             spi_miso,
    output logic [spi_cmd_pkg::CMD_W-1:0]    cmd_read,
    output logic                             cmd_valid,
    input  wire  [spi_cmd_pkg::RESP_W-1:0]   resp_word
);

    logic sync_sck, sync_ss, sync_mosi;
    logic sck_q, ss_q;
    logic sck_rise;
    logic ss_rise_q, ss_fall_q;

    logic [spi_cmd_pkg::CMD_W-1:0]  in_reg;
    logic [spi_cmd_pkg::RESP_W-1:0] out_reg;
    logic [$clog2(spi_cmd_pkg::CMD_W + 1)-1:0] bit_cnt;   // sampled bits, saturating.

    // ~~~~~~~~~~~~~~~~~~~~
    // pin synchronizers
    // ~~~~~~~~~~~~~~~~~~~~
    sync_sig #(.RST_VAL(1'b0)) u_sync_sck (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_clk),
        .out_sig (sync_sck)
    );

    sync_sig #(.RST_VAL(1'b1)) u_sync_ss (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_ss),
        .out_sig (sync_ss)
    );

    sync_sig #(.RST_VAL(1'b0)) u_sync_mosi (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_mosi),
        .out_sig (sync_mosi)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // edge detection
    // ~~~~~~~~~~~~~~~~~~~~
    assign sck_rise = sync_sck & ~sck_q;   // aligned with sync_mosi.

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sck_q     <= 1'b0;
            ss_q      <= 1'b1;
            ss_rise_q <= 1'b0;
            ss_fall_q <= 1'b0;
        end else begin
            sck_q     <= sync_sck;
            ss_q      <= sync_ss;
            ss_rise_q <= sync_ss & ~ss_q;   // frame end.
            ss_fall_q <= ~sync_ss & ss_q;   // frame start.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // shifters and bit count
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            in_reg  <= '0;
            out_reg <= '0;
            bit_cnt <= '0;
        end else if (ss_fall_q) begin
            in_reg  <= '0;
            out_reg <= resp_word;           // response to the previous frame.
            bit_cnt <= '0;
        end else if (!sync_ss && sck_rise) begin
            in_reg  <= {in_reg[spi_cmd_pkg::CMD_W-2:0], sync_mosi};
            out_reg <= {out_reg[spi_cmd_pkg::RESP_W-2:0], 1'b0};
            if (bit_cnt != '1) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    assign spi_miso = out_reg[spi_cmd_pkg::RESP_W-1];

    // frames of any other length are simply never published
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= ss_rise_q && (bit_cnt == spi_cmd_pkg::CMD_W);
        end
    end

    always_ff @(posedge clk) begin
        if (ss_rise_q && (bit_cnt == spi_cmd_pkg::CMD_W)) begin
            cmd_read <= in_reg;             // held until the next good frame.
        end
    end

endmodule

`default_nettype wire

// File: spi_stim.txt
# columns: frame length in bits, command word (hex, op addr data),
# expected response shifted out during this frame (hex, op status data)
56 00000000000000 000000000000
56 010003DEADBEEF 000000000000
56 01000712345678 0100DEADBEEF
56 02000300000000 010012345678
56 020007FFFFFFFF 0200DEADBEEF
56 02000000000000 020012345678
56 7E000311111111 020000000000
56 02000300000000 7E0100000000
56 01001033333333 0200DEADBEEF
56 01800344444444 010200000000
56 02001000000000 010200000000
56 02000300000000 020200000000
40 01000355555555 0200DEADBEEF
56 02000700000000 0200DEADBEEF
60 01000766666666 020012345678
56 02000300000000 020012345678
56 02000700000000 0200DEADBEEF
56 00000000000000 020012345678
56 00000000000000 000000000000

// File: sync_sig.sv
`timescale 1ns/1ps
`default_nettype none

module sync_sig #(
    parameter bit RST_VAL = 1'b0     // idle level of the synchronized pin.
) (
    input  wire  clk,
    input  wire  nrst,
    input  wire  in_sig,
    output logic out_sig
);

    logic meta;                      // first stage, may go metastable.

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            meta    <= RST_VAL;
            out_sig <= RST_VAL;
        end else begin
            meta    <= in_sig;
            out_sig <= meta;
        end
    end

endmodule

`default_nettype wire

// File: tb_spi_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_cmd;

    localparam int MAX_FRAMES = 64;
    localparam int WAIT_LIMIT = 2000;

    logic clk;
    logic nrst;
    logic spi_clk;
    logic spi_ss;
    logic spi_mosi;
    wire  spi_miso;

    int                              frame_len [MAX_FRAMES];
    logic [spi_cmd_pkg::CMD_W-1:0]   frame_cmd [MAX_FRAMES];
    int                              num_frames;
    int                              pass_cnt;
    int                              fail_cnt;
    logic                            chk_done;
    logic                            chk_hung;

    always #2 clk = ~clk;                          // 4 ns period.

    spi_cmd_top u_spi_cmd_top (
        .clk      (clk),
        .nrst     (nrst),
        .spi_clk  (spi_clk),
        .spi_ss   (spi_ss),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    spi_checker u_spi_checker (
        .clk      (clk),
        .spi_clk  (spi_clk),
        .spi_ss   (spi_ss),
        .spi_miso (spi_miso),
        .pass_cnt (pass_cnt),
        .fail_cnt (fail_cnt),
        .done     (chk_done),
        .hung     (chk_hung)
    );

    task automatic load_frames(output int count);
        int                             fd;
        int                             len;
        logic [spi_cmd_pkg::CMD_W-1:0]  cmd;
        logic [spi_cmd_pkg::RESP_W-1:0] rsp;
        string                          line;
        count = 0;
        fd = $fopen("spi_stim.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%d %h %h", len, cmd, rsp) == 3 && count < MAX_FRAMES) begin
                frame_len[count] = len;
                frame_cmd[count] = cmd;
                count++;
            end
        end
        $fclose(fd);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // spi master
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;                                        // drive just after the edge.
    endtask

    task automatic send_frame(input int len, input logic [spi_cmd_pkg::CMD_W-1:0] cmd,
                              input int half);
        spi_ss = 1'b0;
        step(half);
        for (int i = 0; i < len; i++) begin
            // bits past the command word are padded with zeros
            spi_mosi = (i < spi_cmd_pkg::CMD_W) ? cmd[spi_cmd_pkg::CMD_W-1-i] : 1'b0;
            step(half);
            spi_clk = 1'b1;
            step(half);
            spi_clk = 1'b0;
        end
        step(half);
        spi_ss   = 1'b1;
        spi_mosi = 1'b0;
        step(20);                                  // gap between frames.
    endtask

    initial begin
        int seed_val;
        int half_per;
        int wait_cnt;
        clk      = 1'b0;
        nrst     = 1'b0;
        spi_clk  = 1'b0;
        spi_ss   = 1'b1;
        spi_mosi = 1'b0;
        seed_val = $urandom(16);
        load_frames(num_frames);
        if (num_frames <= 0) begin
            $display("no frame could be read from spi_stim.txt");
            $display("TEST RESULT: FAIL");
        end else begin
            step(16);
            nrst = 1'b1;
            step(20);
            for (int f = 0; f < num_frames; f++) begin
                half_per = 6 + int'($urandom % 5);   // 6 to 10 clk cycles.
                send_frame(frame_len[f], frame_cmd[f], half_per);
            end
            wait_cnt = 0;
            while (!chk_done && wait_cnt < WAIT_LIMIT) begin
                @(posedge clk);
                wait_cnt++;
            end
            if (!chk_done) begin
                $display("checker did not finish within %0d cycles", WAIT_LIMIT);
            end
            $display("frames %0d, passed %0d, failed %0d", num_frames, pass_cnt, fail_cnt);
            if (chk_done && !chk_hung && fail_cnt == 0 && pass_cnt == num_frames) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire
